// ==== rtl/synth_settings.svh ====
`ifndef SYNTH_SETTINGS_SVH
`define SYNTH_SETTINGS_SVH

// Number of oscillator voices, 2, 4 or 8
`define SYNTH_VOICE_COUNT 4

// Signed audio sample width
`define SYNTH_SAMPLE_W 16

// Sample period counter width and its value out of reset
`define SYNTH_PERIOD_W 14
`define SYNTH_RESET_PERIOD 64

`endif

// ==== rtl/synth_ctrl_pkg.sv ====
package synth_ctrl_pkg;

    // Command opcodes on the cmd_op port
    typedef enum logic [2:0] {
        OP_SET_FREQ   = 3'd0,  // cmd_data is the phase increment
        OP_SET_VOLUME = 3'd1,  // cmd_data[7:0]
        OP_SET_WAVE   = 3'd2,  // cmd_data[1:0] as wave_t
        OP_KEY_ON     = 3'd3,
        OP_KEY_OFF    = 3'd4,
        OP_SET_PERIOD = 3'd5   // Shared, cmd_voice ignored
    } synth_op_t;

endpackage

// ==== rtl/synth_voice_pkg.sv ====
package synth_voice_pkg;

    // Waveform select per voice
    typedef enum logic [1:0] {
        WAVE_OFF      = 2'd0,
        WAVE_SQUARE   = 2'd1,
        WAVE_SAW      = 2'd2,
        WAVE_TRIANGLE = 2'd3
    } wave_t;

    // Oscillator sample pipeline
    typedef enum logic [1:0] {
        V_SHAPE = 2'd0,  // Raw waveform from phase
        V_SCALE = 2'd1,  // Volume multiply
        V_OFFER = 2'd2   // Waiting for mixer handshake
    } voice_state_t;

endpackage

// ==== rtl/voice_regs.sv ====
`timescale 1ns/10ps
`include "synth_settings.svh"

module voice_regs import synth_ctrl_pkg::*, synth_voice_pkg::*; (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   frame,
    input  logic                                   cmd_valid,
    input  synth_op_t                              cmd_op,
    input  logic [$clog2(`SYNTH_VOICE_COUNT)-1:0]  cmd_voice,
    input  logic [15:0]                            cmd_data,
    output logic [`SYNTH_PERIOD_W-1:0]             sample_period,
    output logic [15:0]                            freq        [`SYNTH_VOICE_COUNT-1:0],
    output logic [7:0]                             volume      [`SYNTH_VOICE_COUNT-1:0],
    output wave_t                                  wave        [`SYNTH_VOICE_COUNT-1:0],
    output logic                                   keyed       [`SYNTH_VOICE_COUNT-1:0],
    output logic                                   phase_clear [`SYNTH_VOICE_COUNT-1:0]
);

    localparam VC      = `SYNTH_VOICE_COUNT;
    localparam VOICE_W = $clog2(VC);
    localparam PW      = `SYNTH_PERIOD_W;

    logic [PW-1:0] sh_period;
    logic [15:0]   sh_freq   [VC-1:0];
    logic [7:0]    sh_volume [VC-1:0];
    wave_t         sh_wave   [VC-1:0];
    logic          sh_keyed  [VC-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            sh_period     <= PW'(`SYNTH_RESET_PERIOD);
            sample_period <= PW'(`SYNTH_RESET_PERIOD);
            for (int i = 0; i < VC; i++) begin
                sh_freq[i]     <= '0;
                sh_volume[i]   <= '0;
                sh_wave[i]     <= WAVE_OFF;
                sh_keyed[i]    <= 1'b0;
                freq[i]        <= '0;
                volume[i]      <= '0;
                wave[i]        <= WAVE_OFF;
                keyed[i]       <= 1'b0;
                phase_clear[i] <= 1'b0;
            end
        end else begin
            // ************************************************************
            // Command decode into shadow registers
            if (cmd_valid && cmd_op == OP_SET_PERIOD) begin
                sh_period <= cmd_data[PW-1:0];
            end
            for (int i = 0; i < VC; i++) begin
                if (cmd_valid && cmd_voice == VOICE_W'(i)) begin
                    case (cmd_op)
                        OP_SET_FREQ:   sh_freq[i]   <= cmd_data;
                        OP_SET_VOLUME: sh_volume[i] <= cmd_data[7:0];
                        OP_SET_WAVE:   sh_wave[i]   <= wave_t'(cmd_data[1:0]);
                        OP_KEY_ON:     sh_keyed[i]  <= 1'b1;
                        OP_KEY_OFF:    sh_keyed[i]  <= 1'b0;
                        default: ;
                    endcase
                end
            end

            // ************************************************************
            // Frame boundary copy to live settings
            for (int i = 0; i < VC; i++) begin
                phase_clear[i] <= frame && sh_keyed[i] && !keyed[i];  // Key-on edge
                if (frame) begin
                    freq[i]   <= sh_freq[i];
                    volume[i] <= sh_volume[i];
                    wave[i]   <= sh_wave[i];
                    keyed[i]  <= sh_keyed[i];
                end
            end
            if (frame) begin
                sample_period <= sh_period;
            end
        end
    end

endmodule

// ==== rtl/tone_voice.sv ====
`timescale 1ns/10ps
`include "synth_settings.svh"

module tone_voice import synth_voice_pkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [15:0]                freq,
    input  logic [7:0]                 volume,
    input  wave_t                      wave,
    input  logic                       keyed,
    input  logic                       phase_clear,
    input  logic                       sample_ready,
    output logic [`SYNTH_SAMPLE_W-1:0] sample,
    output logic                       sample_valid
);

    voice_state_t state;
    logic [15:0]  phase;
    logic         clear_pend;  // Key-on seen while a sample was on offer

    logic [15:0]  saw;
    logic [14:0]  fold;
    logic [15:0]  shape;
    logic [15:0]  raw;
    logic signed [24:0] product;
    logic         handshake;

    assign sample_valid = (state == V_OFFER);
    assign handshake    = sample_valid && sample_ready;

    // ************************************************************
    // Waveform from phase
    always_comb begin
        saw  = {~phase[15], phase[14:0]};
        fold = saw[15] ? ~saw[14:0] : saw[14:0];  // Distance from midpoint
        if (!keyed) begin
            shape = '0;
        end else begin
            case (wave)
                WAVE_SQUARE:   shape = phase[15] ? 16'h8000 : 16'h7fff;
                WAVE_SAW:      shape = saw;
                WAVE_TRIANGLE: shape = {~fold[14], fold[13:0], 1'b0};  // 2*fold - 32768
                default:       shape = '0;
            endcase
        end
    end

    assign product = $signed(raw) * $signed({1'b0, volume});

    always_ff @(posedge clk) begin
        if (state == V_SHAPE) begin
            raw <= shape;
        end
        if (state == V_SCALE) begin
            sample <= product[23:8];  // Arithmetic shift by 8
        end
    end

    // ************************************************************
    // Sample pipeline and phase accumulator
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= V_SHAPE;
            phase      <= '0;
            clear_pend <= 1'b0;
        end else begin
            case (state)
                V_SHAPE: state <= V_SCALE;
                V_SCALE: state <= V_OFFER;
                V_OFFER: begin
                    if (handshake) begin
                        // A pending key-on restarts the next sample at phase zero
                        phase      <= (clear_pend || phase_clear) ? 16'h0000 : phase + freq;
                        clear_pend <= 1'b0;
                        state      <= V_SHAPE;
                    end else if (phase_clear) begin
                        clear_pend <= 1'b1;  // Keep the sample already on offer
                    end
                end
                default: state <= V_SHAPE;
            endcase

            if (phase_clear && state != V_OFFER) begin
                phase <= '0;
                state <= V_SHAPE;
            end
        end
    end

endmodule

// ==== rtl/sample_mixer.sv ====
`timescale 1ns/10ps
`include "synth_settings.svh"

module sample_mixer #(
    parameter VOICE_COUNT = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`SYNTH_PERIOD_W-1:0] sample_period,
    input  logic [`SYNTH_SAMPLE_W-1:0] din       [VOICE_COUNT-1:0],
    input  logic                       din_valid [VOICE_COUNT-1:0],
    output logic                       din_ready [VOICE_COUNT-1:0],
    output logic [`SYNTH_SAMPLE_W-1:0] dout,
    output logic                       dout_valid
);

    localparam SW    = `SYNTH_SAMPLE_W;
    localparam PW    = `SYNTH_PERIOD_W;
    localparam IDX_W = (VOICE_COUNT > 1) ? $clog2(VOICE_COUNT) : 1;

    localparam logic [SW-1:0] SAT_MAX = {1'b0, {(SW-1){1'b1}}};
    localparam logic [SW-1:0] SAT_MIN = {1'b1, {(SW-1){1'b0}}};

    logic             prev_rst;  // First cycle out of reset
    logic [PW-1:0]    sample_counter;
    logic [PW-1:0]    period_last;
    logic [IDX_W-1:0] voice_idx;
    logic             active_ready [VOICE_COUNT-1:0];

    logic [SW-1:0]    cur;
    logic [SW-1:0]    next_sum;
    logic             handshake;
    logic             period_end;

    assign period_last = sample_period - 1'b1;
    assign period_end  = (sample_counter == period_last);
    assign cur         = din[voice_idx];
    assign next_sum    = dout + cur;
    assign handshake   = din_valid[voice_idx] && din_ready[voice_idx];

    // Only the selected voice sees its ready
    always_comb begin
        for (int i = 0; i < VOICE_COUNT; i++) begin
            din_ready[i] = (voice_idx == IDX_W'(i)) ? active_ready[i] : 1'b0;
        end
    end

    // ************************************************************
    // Round-robin voice select
    always_ff @(posedge clk) begin
        if (rst) begin
            voice_idx <= '0;
        end else if (voice_idx == IDX_W'(VOICE_COUNT - 1)) begin
            voice_idx <= '0;
        end else begin
            voice_idx <= voice_idx + 1'b1;
        end
    end

    // ************************************************************
    // Period counter, accumulator and readies
    always_ff @(posedge clk) begin
        if (rst) begin
            sample_counter <= '0;
            dout           <= '0;
            dout_valid     <= 1'b0;
            for (int i = 0; i < VOICE_COUNT; i++) begin
                active_ready[i] <= 1'b0;
            end
        end else begin
            sample_counter <= period_end ? '0 : sample_counter + 1'b1;
            dout_valid     <= period_end;  // Sum is final during this pulse

            if (sample_counter == '0) begin
                dout <= handshake ? cur : '0;  // Reload for a new period
            end else if (handshake) begin
                if (!next_sum[SW-1] && cur[SW-1] && dout[SW-1]) begin
                    dout <= SAT_MIN;  // Negative plus negative wrapped
                end else if (next_sum[SW-1] && !cur[SW-1] && !dout[SW-1]) begin
                    dout <= SAT_MAX;
                end else begin
                    dout <= next_sum;
                end
            end

            if (period_end || prev_rst) begin
                for (int i = 0; i < VOICE_COUNT; i++) begin
                    active_ready[i] <= 1'b1;
                end
            end else if (handshake) begin
                active_ready[voice_idx] <= 1'b0;  // One sample per voice per period
            end
        end
        prev_rst <= rst;
    end

endmodule

// ==== rtl/synth_core.sv ====
`timescale 1ns/10ps
`include "synth_settings.svh"

module synth_core import synth_ctrl_pkg::*, synth_voice_pkg::*; (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  cmd_valid,
    input  synth_op_t                             cmd_op,
    input  logic [$clog2(`SYNTH_VOICE_COUNT)-1:0] cmd_voice,
    input  logic [15:0]                           cmd_data,
    output logic [`SYNTH_SAMPLE_W-1:0]            dout,
    output logic                                  dout_valid
);

    localparam VC = `SYNTH_VOICE_COUNT;

    logic [`SYNTH_PERIOD_W-1:0] sample_period;
    logic [15:0]                freq         [VC-1:0];
    logic [7:0]                 volume       [VC-1:0];
    wave_t                      wave         [VC-1:0];
    logic                       keyed        [VC-1:0];
    logic                       phase_clear  [VC-1:0];
    logic [`SYNTH_SAMPLE_W-1:0] sample       [VC-1:0];
    logic                       sample_valid [VC-1:0];
    logic                       sample_ready [VC-1:0];

    // Mixer output pulse is the frame boundary
    voice_regs regs_i (
        .clk           (clk),
        .rst           (rst),
        .frame         (dout_valid),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_voice     (cmd_voice),
        .cmd_data      (cmd_data),
        .sample_period (sample_period),
        .freq          (freq),
        .volume        (volume),
        .wave          (wave),
        .keyed         (keyed),
        .phase_clear   (phase_clear)
    );

    for (genvar v = 0; v < VC; v++) begin : g_voice
        tone_voice voice_i (
            .clk          (clk),
            .rst          (rst),
            .freq         (freq[v]),
            .volume       (volume[v]),
            .wave         (wave[v]),
            .keyed        (keyed[v]),
            .phase_clear  (phase_clear[v]),
            .sample_ready (sample_ready[v]),
            .sample       (sample[v]),
            .sample_valid (sample_valid[v])
        );
    end

    sample_mixer #(
        .VOICE_COUNT (VC)
    ) mixer_i (
        .clk           (clk),
        .rst           (rst),
        .sample_period (sample_period),
        .din           (sample),
        .din_valid     (sample_valid),
        .din_ready     (sample_ready),
        .dout          (dout),
        .dout_valid    (dout_valid)
    );

endmodule

// ==== tb/synth_checker.sv ====
`timescale 1ns/10ps
`include "synth_settings.svh"

module synth_checker import synth_ctrl_pkg::*, synth_voice_pkg::*; (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  cmd_valid,
    input  synth_op_t                             cmd_op,
    input  logic [$clog2(`SYNTH_VOICE_COUNT)-1:0] cmd_voice,
    input  logic [15:0]                           cmd_data,
    input  logic [`SYNTH_SAMPLE_W-1:0]            dout,
    input  logic                                  dout_valid,
    input  logic [3:0]                            test_id,
    output int                                    out_count,
    output int                                    value_errors,
    output int                                    timing_errors
);

    localparam VC = `SYNTH_VOICE_COUNT;

    typedef struct packed {
        logic [15:0] freq;
        logic [7:0]  volume;
        wave_t       wave;
        logic        keyed;
    } voice_cfg_t;

    voice_cfg_t  sh_cfg [VC];
    voice_cfg_t  l1_cfg [VC];  // Live since the latest pulse
    voice_cfg_t  l2_cfg [VC];  // Shapes the samples in the coming output
    voice_cfg_t  l3_cfg [VC];
    int          sh_period;
    int          l1_period;
    logic [15:0] phase  [VC];
    int          cyc;
    int          last_pulse;
    int          acc;
    logic [15:0] expected;

    function automatic string test_name(input logic [3:0] id);
        case (id)
            4'd0:    return "reset_silence";
            4'd1:    return "single_square";
            4'd2:    return "single_saw";
            4'd3:    return "single_triangle";
            4'd4:    return "random_mix";
            4'd5:    return "saturation";
            4'd6:    return "period_change";
            default: return "key_off_on";
        endcase
    endfunction

    // Waveform from phase, then volume scaling with floor division by 256
    function automatic int voice_sample(input voice_cfg_t cfg, input logic [15:0] ph);
        int raw;
        int s;
        int mag;
        s = int'(ph) - 32768;
        mag = (s < 0) ? -s - 1 : s;
        if (!cfg.keyed) begin
            raw = 0;
        end else begin
            case (cfg.wave)
                WAVE_SQUARE:   raw = ph[15] ? -32768 : 32767;
                WAVE_SAW:      raw = s;
                WAVE_TRIANGLE: raw = 2 * mag - 32768;
                default:       raw = 0;
            endcase
        end
        return (raw * int'(cfg.volume)) >>> 8;
    endfunction

    function automatic int sat_add(input int a, input int b);
        int sum;
        sum = a + b;
        if (sum > 32767) return 32767;
        if (sum < -32768) return -32768;
        return sum;
    endfunction

    // ************************************************************
    // Falling edge sees what the DUT takes at the next rising edge
    always @(negedge clk) begin
        if (rst) begin
            for (int v = 0; v < VC; v++) begin
                sh_cfg[v] = '0;
                l1_cfg[v] = '0;
                l2_cfg[v] = '0;
                l3_cfg[v] = '0;
                phase[v]  = '0;
            end
            sh_period     = `SYNTH_RESET_PERIOD;
            l1_period     = `SYNTH_RESET_PERIOD;
            cyc           = 0;
            last_pulse    = 0;
            out_count     = 0;
            value_errors  = 0;
            timing_errors = 0;
        end else begin
            if (dout_valid) begin
                if (cyc - last_pulse != l1_period) begin
                    timing_errors++;
                    $display("output pulse came %0d cycles after the previous one, not %0d (%s)",
                             cyc - last_pulse, l1_period, test_name(test_id));
                end
                last_pulse = cyc;
                for (int v = 0; v < VC; v++) begin
                    if (l2_cfg[v].keyed && !l3_cfg[v].keyed) begin
                        phase[v] = '0;  // Key-on restart
                    end else begin
                        phase[v] = phase[v] + l2_cfg[v].freq;
                    end
                    if (v == 0) begin
                        acc = voice_sample(l2_cfg[v], phase[v]);
                    end else begin
                        acc = sat_add(acc, voice_sample(l2_cfg[v], phase[v]));
                    end
                end
                expected = 16'(acc);
                if (dout !== expected) begin
                    value_errors++;
                    $display("mismatch in %s: expected %h, actual %h",
                             test_name(test_id), expected, dout);
                end
                out_count++;
                l3_cfg    = l2_cfg;
                l2_cfg    = l1_cfg;
                l1_cfg    = sh_cfg;
                l1_period = sh_period;
            end
            if (cmd_valid) begin
                case (cmd_op)
                    OP_SET_FREQ:   sh_cfg[cmd_voice].freq   = cmd_data;
                    OP_SET_VOLUME: sh_cfg[cmd_voice].volume = cmd_data[7:0];
                    OP_SET_WAVE:   sh_cfg[cmd_voice].wave   = wave_t'(cmd_data[1:0]);
                    OP_KEY_ON:     sh_cfg[cmd_voice].keyed  = 1'b1;
                    OP_KEY_OFF:    sh_cfg[cmd_voice].keyed  = 1'b0;
                    OP_SET_PERIOD: sh_period = int'(cmd_data[`SYNTH_PERIOD_W-1:0]);
                    default: ;
                endcase
            end
            cyc++;
        end
    end

endmodule

// ==== tb/synth_core_tb.sv ====
`timescale 1ns/10ps
`include "synth_settings.svh"

module synth_core_tb import synth_ctrl_pkg::*, synth_voice_pkg::*; ();

    localparam VC           = `SYNTH_VOICE_COUNT;
    localparam VOICE_W      = $clog2(VC);
    localparam TOTAL_FRAMES = 64;
    localparam MAX_PERIOD   = 128;
    localparam LIMIT_CYCLES = TOTAL_FRAMES * MAX_PERIOD * 2 + 200;

    logic                       clk;
    logic                       rst;
    logic                       cmd_valid;
    synth_op_t                  cmd_op;
    logic [VOICE_W-1:0]         cmd_voice;
    logic [15:0]                cmd_data;
    logic [`SYNTH_SAMPLE_W-1:0] dout;
    logic                       dout_valid;
    logic [3:0]                 test_id;
    int                         out_count;
    int                         value_errors;
    int                         timing_errors;
    int                         other_errors = 0;
    logic [31:0]                rng;

    synth_core dut_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_voice  (cmd_voice),
        .cmd_data   (cmd_data),
        .dout       (dout),
        .dout_valid (dout_valid)
    );

    synth_checker checker_i (
        .clk           (clk),
        .rst           (rst),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_voice     (cmd_voice),
        .cmd_data      (cmd_data),
        .dout          (dout),
        .dout_valid    (dout_valid),
        .test_id       (test_id),
        .out_count     (out_count),
        .value_errors  (value_errors),
        .timing_errors (timing_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Called and returns 1 ns after a rising edge
    task automatic send_cmd(input synth_op_t op, input int voice, input logic [15:0] data);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_voice = VOICE_W'(voice);
        cmd_data  = data;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    task automatic program_voice(input int v, input logic [15:0] f, input logic [7:0] vol,
                                 input wave_t w);
        send_cmd(OP_SET_FREQ, v, f);
        send_cmd(OP_SET_VOLUME, v, {8'h00, vol});
        send_cmd(OP_SET_WAVE, v, {14'h0, w});
    endtask

    task automatic key_off_all();
        for (int v = 0; v < VC; v++) begin
            send_cmd(OP_KEY_OFF, v, 16'h0);
        end
    endtask

    task automatic wait_frames(input int n);
        repeat (n) begin
            do @(negedge clk); while (dout_valid !== 1'b1);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d value, %0d timing, %0d other, %0d outputs checked",
                 value_errors, timing_errors, other_errors, out_count);
        if (value_errors + timing_errors + other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // ************************************************************
    // Stimulus
    initial begin
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_op    = OP_SET_FREQ;
        cmd_voice = '0;
        cmd_data  = '0;
        test_id   = 4'd0;
        rng       = 32'hd700ee07;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        wait_frames(5);

        test_id = 4'd1;
        program_voice(0, 16'h0a31, 8'hff, WAVE_SQUARE);
        send_cmd(OP_KEY_ON, 0, 16'h0);
        wait_frames(6);
        test_id = 4'd2;
        send_cmd(OP_SET_WAVE, 0, {14'h0, WAVE_SAW});
        wait_frames(6);
        test_id = 4'd3;
        send_cmd(OP_SET_WAVE, 0, {14'h0, WAVE_TRIANGLE});
        wait_frames(6);

        test_id = 4'd4;
        key_off_all();
        wait_frames(3);
        for (int v = 0; v < VC; v++) begin
            rng = xorshift32(rng);
            program_voice(v, rng[15:0], rng[23:16], wave_t'(rng[25:24]));
            send_cmd(OP_KEY_ON, v, 16'h0);
        end
        wait_frames(8);

        test_id = 4'd5;
        key_off_all();
        wait_frames(3);
        for (int v = 0; v < VC; v++) begin
            program_voice(v, 16'h4000, 8'hff, WAVE_SQUARE);  // Quarter turn per sample
            send_cmd(OP_KEY_ON, v, 16'h0);
        end
        wait_frames(6);

        test_id = 4'd6;
        send_cmd(OP_SET_PERIOD, 0, 16'd32);
        for (int v = 0; v < VC; v++) begin
            send_cmd(OP_SET_VOLUME, v, 16'h0040);
        end
        wait_frames(6);
        send_cmd(OP_SET_PERIOD, 0, 16'd128);
        wait_frames(4);

        test_id = 4'd7;
        send_cmd(OP_KEY_OFF, 1, 16'h0);
        wait_frames(4);
        send_cmd(OP_KEY_ON, 1, 16'h0);
        wait_frames(7);

        finish_run();
    end

    // Watchdog sized for every planned output at the longest period
    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        other_errors++;
        $display("timeout after %0d cycles, the DUT stopped producing output pulses",
                 LIMIT_CYCLES);
        finish_run();
    end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/synth_ctrl_pkg.sv
rtl/synth_voice_pkg.sv
rtl/voice_regs.sv
rtl/tone_voice.sv
rtl/sample_mixer.sv
rtl/synth_core.sv
tb/synth_checker.sv
tb/synth_core_tb.sv

// ==== Bender.yml ====
package:
  name: synth_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/synth_ctrl_pkg.sv
      - rtl/synth_voice_pkg.sv
      - rtl/voice_regs.sv
      - rtl/tone_voice.sv
      - rtl/sample_mixer.sv
      - rtl/synth_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/synth_checker.sv
      - tb/synth_core_tb.sv
